//--- alu/aluUnit.sv
// Multicycle ALU, single-cycle logic and arithmetic plus iterative multiply and divide into Z
`timescale 1ns/1ps

module aluUnit (
   input  logic                         Clock,
   input  logic                         rstN,
   input  logic [aluPkg::dataWidth-1:0] busValue,
   input  logic [aluPkg::dataWidth-1:0] yData,
   input  aluPkg::aluOp                 op,
   input  logic                         start,
   output logic                         finished,
   srcBusIf.aluSrc                      src
);
   import aluPkg::*;

   typedef enum logic [1:0] {
      idle,
      mulRun,
      divRun
   } aluState;

   localparam int cntWidth = $clog2(iterSteps);

   aluState              state;
   logic [cntWidth-1:0]  stepCnt;
   logic                 lastStep;
   // Multiplicand during multiply, divisor during divide
   logic [dataWidth-1:0] operand;
   // Partial product or remainder in the high word, multiplier or quotient in the low word
   logic [dataWidth-1:0] workHi;
   logic [dataWidth-1:0] workLo;
   logic [dataWidth-1:0] nextHi;
   logic [dataWidth-1:0] nextLo;
   logic [dataWidth:0]   mulSum;
   logic [dataWidth:0]   remShift;
   logic [dataWidth:0]   remDiff;
   logic [dataWidth-1:0] singleResult;
   logic [dataWidth-1:0] zHi;
   logic [dataWidth-1:0] zLo;

   always_comb begin
      case (op)
         opAdd:   singleResult = yData + busValue;
         opSub:   singleResult = yData - busValue;
         opAnd:   singleResult = yData & busValue;
         opOr:    singleResult = yData | busValue;
         opShl:   singleResult = yData << busValue[4:0];
         opShr:   singleResult = yData >> busValue[4:0];
         opNeg:   singleResult = -busValue;
         opNot:   singleResult = ~busValue;
         default: singleResult = '0;
      endcase
   end

   // One iteration of shift-add multiply or restoring divide
   always_comb begin
      mulSum   = {1'b0, workHi} + (workLo[0] ? {1'b0, operand} : '0);
      remShift = {workHi, workLo[dataWidth-1]};
      remDiff  = remShift - {1'b0, operand};
      if (state == mulRun) begin
         nextHi = mulSum[dataWidth:1];
         nextLo = {mulSum[0], workLo[dataWidth-1:1]};
      end else if (remShift >= {1'b0, operand}) begin
         // A zero divisor always subtracts, leaving all ones and the dividend
         nextHi = remDiff[dataWidth-1:0];
         nextLo = {workLo[dataWidth-2:0], 1'b1};
      end else begin
         nextHi = remShift[dataWidth-1:0];
         nextLo = {workLo[dataWidth-2:0], 1'b0};
      end
   end

   assign lastStep = (stepCnt == cntWidth'(iterSteps - 1));

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         state    <= idle;
         stepCnt  <= '0;
         operand  <= '0;
         workHi   <= '0;
         workLo   <= '0;
         zHi      <= '0;
         zLo      <= '0;
         finished <= 1'b0;
      end else begin
         finished <= 1'b0;
         if (state == idle) begin
            if (start) begin
               stepCnt <= '0;
               workHi  <= '0;
               if (op == opMul) begin
                  state   <= mulRun;
                  operand <= yData;
                  workLo  <= busValue;
               end else if (op == opDiv) begin
                  state   <= divRun;
                  operand <= busValue;
                  workLo  <= yData;
               end else begin
                  zHi      <= '0;
                  zLo      <= singleResult;
                  finished <= 1'b1;
               end
            end
         end else begin
            workHi  <= nextHi;
            workLo  <= nextLo;
            stepCnt <= stepCnt + 1'b1;
            // Product halves or remainder and quotient land in Z together
            if (lastStep) begin
               state    <= idle;
               zHi      <= nextHi;
               zLo      <= nextLo;
               finished <= 1'b1;
            end
         end
      end
   end

   assign src.zHiData = zHi;
   assign src.zLoData = zLo;

endmodule

//--- busDatapath.f
common/aluPkg.sv
common/isaPkg.sv
common/srcBusIf.sv
hdl/regFile.sv
hdl/specialRegs.sv
alu/aluUnit.sv
hdl/busMux.sv
hdl/dataPath.sv
test/dataPathTb.sv

//--- common/aluPkg.sv
// ALU data width and opcode set, imported by the ALU, the datapath top and the testbench
package aluPkg;

   // Width of the bus and of every register
   localparam int dataWidth = 32;

   // Multiply and divide iterate once per operand bit
   localparam int iterSteps = dataWidth;

   // Opcodes presented on op while start is high
   typedef enum logic [4:0] {
      // A plus B
      opAdd = 5'd0,
      // A minus B
      opSub = 5'd1,
      // Bitwise logic on A and B
      opAnd = 5'd2,
      opOr  = 5'd3,
      // Shift A by the low 5 bits of B
      opShl = 5'd4,
      opShr = 5'd5,
      // Unary, applied to B
      opNeg = 5'd6,
      opNot = 5'd7,
      // Multicycle, 64-bit result split over Z high and Z low
      opMul = 5'd8,
      opDiv = 5'd9
   } aluOp;

endpackage

//--- common/isaPkg.sv
// Instruction format and register-side constants, imported by the register file and special registers
package isaPkg;

   // General register count, selected by 4-bit IR fields
   localparam int numRegs = 16;

   // Register fields of the instruction word
   localparam int raHi = 26;
   localparam int raLo = 23;
   localparam int rbHi = 22;
   localparam int rbLo = 19;
   localparam int rcHi = 18;
   localparam int rcLo = 15;

   // Immediate in IR bits 18 down to 0, sign-extended
   localparam int immWidth = 19;

   localparam int unsigned resetPc = 0;

endpackage

//--- common/srcBusIf.sv
// Bundle of all bus source values, driven by the producers and read by the bus multiplexer
`timescale 1ns/1ps

interface srcBusIf;
   import aluPkg::*;

   logic [dataWidth-1:0] rfData;
   logic [dataWidth-1:0] pcData;
   logic [dataWidth-1:0] immData;
   logic [dataWidth-1:0] mdrData;
   logic [dataWidth-1:0] yData;
   logic [dataWidth-1:0] hiData;
   logic [dataWidth-1:0] loData;
   logic [dataWidth-1:0] zHiData;
   logic [dataWidth-1:0] zLoData;

   // One modport per producer
   modport rfSrc (output rfData);
   modport regSrc (output pcData, immData, mdrData, yData, hiData, loData);
   modport aluSrc (output zHiData, zLoData);

   modport sink (input rfData, pcData, immData, mdrData, yData, hiData, loData,
                 zHiData, zLoData);

endinterface

//--- hdl/busMux.sv
// Shared bus driver, picks one source by fixed out-strobe priority
`timescale 1ns/1ps

module busMux (
   input  logic                         extIn,
   input  logic                         rfOut,
   input  logic                         pcOut,
   input  logic                         mdrOut,
   input  logic                         immOut,
   input  logic                         zHiOut,
   input  logic                         zLoOut,
   input  logic                         hiOut,
   input  logic                         loOut,
   input  logic                         yOut,
   input  logic [aluPkg::dataWidth-1:0] extData,
   srcBusIf.sink                        src,
   output logic [aluPkg::dataWidth-1:0] busValue
);

   // External data has top priority, an idle bus reads zero
   always_comb begin
      if (extIn) begin
         busValue = extData;
      end else if (rfOut) begin
         busValue = src.rfData;
      end else if (pcOut) begin
         busValue = src.pcData;
      end else if (mdrOut) begin
         busValue = src.mdrData;
      end else if (immOut) begin
         busValue = src.immData;
      end else if (zHiOut) begin
         busValue = src.zHiData;
      end else if (zLoOut) begin
         busValue = src.zLoData;
      end else if (hiOut) begin
         busValue = src.hiData;
      end else if (loOut) begin
         busValue = src.loData;
      end else if (yOut) begin
         busValue = src.yData;
      end else begin
         busValue = '0;
      end
   end

endmodule

//--- hdl/dataPath.sv
// Datapath top level joining register side, ALU and bus multiplexer behind plain strobe ports
`timescale 1ns/1ps

module dataPath #(
   parameter int memDepth = 64
) (
   input  logic                         Clock,
   input  logic                         rstN,
   // Out-strobes
   input  logic                         extIn,
   input  logic                         rOut,
   input  logic                         pcOut,
   input  logic                         mdrOut,
   input  logic                         immOut,
   input  logic                         zHiOut,
   input  logic                         zLoOut,
   input  logic                         hiOut,
   input  logic                         loOut,
   input  logic                         yOut,
   input  logic                         baOut,
   // Register select and in-strobes
   input  logic                         gra,
   input  logic                         grb,
   input  logic                         grc,
   input  logic                         rIn,
   input  logic                         pcIn,
   input  logic                         incPc,
   input  logic                         irIn,
   input  logic                         marIn,
   input  logic                         mdrIn,
   input  logic                         yIn,
   input  logic                         hiIn,
   input  logic                         loIn,
   input  logic                         read,
   input  logic                         write,
   input  logic                         start,
   input  aluPkg::aluOp                 op,
   input  logic [aluPkg::dataWidth-1:0] extData,
   output logic [aluPkg::dataWidth-1:0] busValue,
   output logic                         finished,
   output logic                         memFinished
);
   import aluPkg::*;

   logic [dataWidth-1:0] irValue;

   srcBusIf srcBus ();

   regFile regFile0 (
      .Clock(Clock), .rstN(rstN), .busValue(busValue), .irValue(irValue),
      .gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut), .baOut(baOut),
      .src(srcBus.rfSrc)
   );

   specialRegs #(.memDepth(memDepth)) specialRegs0 (
      .Clock(Clock), .rstN(rstN), .busValue(busValue), .pcIn(pcIn), .incPc(incPc),
      .irIn(irIn), .marIn(marIn), .mdrIn(mdrIn), .yIn(yIn), .hiIn(hiIn), .loIn(loIn),
      .read(read), .write(write), .memFinished(memFinished), .irValue(irValue),
      .src(srcBus.regSrc)
   );

   // Y feeds the ALU A operand directly
   aluUnit aluUnit0 (
      .Clock(Clock), .rstN(rstN), .busValue(busValue), .yData(srcBus.yData),
      .op(op), .start(start), .finished(finished), .src(srcBus.aluSrc)
   );

   busMux busMux0 (
      .extIn(extIn), .rfOut(rOut), .pcOut(pcOut), .mdrOut(mdrOut), .immOut(immOut),
      .zHiOut(zHiOut), .zLoOut(zLoOut), .hiOut(hiOut), .loOut(loOut), .yOut(yOut),
      .extData(extData), .src(srcBus.sink), .busValue(busValue)
   );

endmodule

//--- hdl/regFile.sv
// General register file, indexed from the IR register fields and loaded from the bus
`timescale 1ns/1ps

module regFile (
   input  logic                         Clock,
   input  logic                         rstN,
   input  logic [aluPkg::dataWidth-1:0] busValue,
   input  logic [aluPkg::dataWidth-1:0] irValue,
   input  logic                         gra,
   input  logic                         grb,
   input  logic                         grc,
   input  logic                         rIn,
   input  logic                         rOut,
   input  logic                         baOut,
   srcBusIf.rfSrc                       src
);
   import aluPkg::*;
   import isaPkg::*;

   localparam int idxWidth = $clog2(numRegs);

   logic [dataWidth-1:0] regs [numRegs];
   logic [idxWidth-1:0]  idx;

   // Field select, ra wins over rb over rc
   always_comb begin
      if (gra) begin
         idx = irValue[raHi:raLo];
      end else if (grb) begin
         idx = irValue[rbHi:rbLo];
      end else if (grc) begin
         idx = irValue[rcHi:rcLo];
      end else begin
         idx = '0;
      end
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (rIn) begin
         regs[idx] <= busValue;
      end
   end

   // R0 reads as zero when used as a base address
   always_comb begin
      if (!rOut || (baOut && idx == '0)) begin
         src.rfData = '0;
      end else begin
         src.rfData = regs[idx];
      end
   end

endmodule

//--- hdl/specialRegs.sv
// PC, IR, MAR, MDR, Y, HI and LO registers with the word-addressed data memory
`timescale 1ns/1ps

module specialRegs #(
   parameter int memDepth = 64
) (
   input  logic                         Clock,
   input  logic                         rstN,
   input  logic [aluPkg::dataWidth-1:0] busValue,
   input  logic                         pcIn,
   input  logic                         incPc,
   input  logic                         irIn,
   input  logic                         marIn,
   input  logic                         mdrIn,
   input  logic                         yIn,
   input  logic                         hiIn,
   input  logic                         loIn,
   input  logic                         read,
   input  logic                         write,
   output logic                         memFinished,
   output logic [aluPkg::dataWidth-1:0] irValue,
   srcBusIf.regSrc                      src
);
   import aluPkg::*;
   import isaPkg::*;

   localparam int addrWidth = $clog2(memDepth);

   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] ir;
   logic [dataWidth-1:0] mar;
   logic [dataWidth-1:0] mdr;
   logic [dataWidth-1:0] y;
   logic [dataWidth-1:0] hi;
   logic [dataWidth-1:0] lo;
   logic [dataWidth-1:0] mem [memDepth];
   logic [addrWidth-1:0] memAddr;

   // Memory is word addressed by the low MAR bits
   assign memAddr = mar[addrWidth-1:0];

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         pc          <= dataWidth'(resetPc);
         ir          <= '0;
         mar         <= '0;
         mdr         <= '0;
         y           <= '0;
         hi          <= '0;
         lo          <= '0;
         memFinished <= 1'b0;
      end else begin
         if (pcIn) begin
            pc <= busValue;
         end else if (incPc) begin
            pc <= pc + 1'b1;
         end
         if (irIn)  ir  <= busValue;
         if (marIn) mar <= busValue;
         if (yIn)   y   <= busValue;
         if (hiIn)  hi  <= busValue;
         if (loIn)  lo  <= busValue;
         // MDR takes memory data during a read, the bus otherwise
         if (mdrIn) mdr <= read ? mem[memAddr] : busValue;
         memFinished <= read | write;
      end
   end

   always_ff @(posedge Clock) begin
      if (write) begin
         mem[memAddr] <= mdr;
      end
   end

   assign irValue     = ir;
   assign src.pcData  = pc;
   assign src.mdrData = mdr;
   assign src.yData   = y;
   assign src.hiData  = hi;
   assign src.loData  = lo;
   assign src.immData = {{(dataWidth - immWidth){ir[immWidth-1]}}, ir[immWidth-1:0]};

endmodule

//--- test/dataPathTb.sv
// Simulation top that drives the datapath strobes cycle by cycle and checks the bus
`timescale 1ns/1ps

module dataPathTb;
   import aluPkg::*;

   // Limit is over three times the length of the tests
   localparam int estCycles     = 600;
   localparam int cycleLimit    = 2000;
   localparam int hangLimit     = 40;
   localparam int mulDivLatency = 33;

   logic Clock = 1'b0;
   logic rstN;
   logic extIn, rOut, pcOut, mdrOut, immOut, zHiOut, zLoOut, hiOut, loOut, yOut, baOut;
   logic gra, grb, grc, rIn, pcIn, incPc, irIn, marIn, mdrIn, yIn, hiIn, loIn;
   logic read, write, start;
   aluOp op;
   logic [dataWidth-1:0] extData;
   logic [dataWidth-1:0] busValue;
   logic finished;
   logic memFinished;
   int   cycleCount = 0;

   dataPath #(.memDepth(64)) dut0 (.*);

   always #50 Clock = ~Clock;

   always @(posedge Clock) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount == cycleLimit) begin
         $display("Timeout: run went past %0d cycles (tests need about %0d)",
                  cycleLimit, estCycles);
         failNow();
      end
   end

   task automatic failNow();
      $display("RESULT: FAIL");
      $fatal(1, "stopping on first error");
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
         failNow();
      end
   endtask

   task automatic clearStrobes();
      extIn  <= 0;
      rOut   <= 0;
      pcOut  <= 0;
      mdrOut <= 0;
      immOut <= 0;
      zHiOut <= 0;
      zLoOut <= 0;
      hiOut  <= 0;
      loOut  <= 0;
      yOut   <= 0;
      baOut  <= 0;
      gra    <= 0;
      grb    <= 0;
      grc    <= 0;
      rIn    <= 0;
      pcIn   <= 0;
      incPc  <= 0;
      irIn   <= 0;
      marIn  <= 0;
      mdrIn  <= 0;
      yIn    <= 0;
      hiIn   <= 0;
      loIn   <= 0;
      read   <= 0;
      write  <= 0;
      start  <= 0;
   endtask

   // Every strobe lasts one cycle unless the caller raises it again
   task automatic nextCycle();
      @(posedge Clock);
      clearStrobes();
   endtask

   task automatic putExt(input logic [31:0] value);
      nextCycle();
      extIn   <= 1;
      extData <= value;
   endtask

   // Combinational bus settles well before the falling edge
   task automatic expectBus(input string name, input logic [31:0] expected);
      @(negedge Clock);
      check(name, busValue, expected);
   endtask

   task automatic loadIr(input logic [31:0] word);
      putExt(word);
      irIn <= 1;
   endtask

   task automatic waitDone(input bit onMem, output int cycles);
      bit seen;
      cycles = 0;
      seen   = 0;
      while (!seen) begin
         nextCycle();
         cycles++;
         @(negedge Clock);
         seen = onMem ? memFinished : finished;
         if (!seen && cycles >= hangLimit) begin
            $display("Hang: %s did not pulse within %0d cycles",
                     onMem ? "memFinished" : "finished", hangLimit);
            failNow();
         end
      end
   endtask

   task automatic startAlu(input aluOp o, input logic [31:0] a, input logic [31:0] b);
      putExt(a);
      yIn <= 1;
      putExt(b);
      op    <= o;
      start <= 1;
   endtask

   function automatic logic [31:0] irWord(input int ra, input int rb, input logic [18:0] imm);
      logic [3:0] raBits;
      logic [3:0] rbBits;
      raBits = ra[3:0];
      rbBits = rb[3:0];
      return {5'b0, raBits, rbBits, imm};
   endfunction

   function automatic logic [31:0] signExt(input logic [18:0] imm);
      return imm[18] ? {13'h1fff, imm} : {13'h0, imm};
   endfunction

   // Expected single-cycle results with A from Y and B from the bus
   function automatic logic [31:0] refResult(input aluOp o, input logic [31:0] a,
                                            input logic [31:0] b);
      case (o)
         opAdd:   return a + b;
         opSub:   return a + ~b + 32'd1;
         opAnd:   return a & b;
         opOr:    return a | b;
         opShl:   return a << b[4:0];
         opShr:   return a >> b[4:0];
         opNeg:   return ~b + 32'd1;
         opNot:   return ~b;
         default: return 32'h0;
      endcase
   endfunction

   task automatic regReadback();
      logic [31:0] vals [16];
      logic [31:0] r0Val;
      for (int k = 1; k < 16; k++) begin
         vals[k] = $urandom;
         loadIr(irWord(k, 0, 19'h0));
         putExt(vals[k]);
         gra <= 1;
         rIn <= 1;
      end
      // Read back through the rb field
      for (int k = 1; k < 16; k++) begin
         loadIr(irWord(0, k, 19'h0));
         nextCycle();
         grb  <= 1;
         rOut <= 1;
         expectBus($sformatf("busValue R%0d", k), vals[k]);
      end
      // The rc field shares its bits with the top of the immediate
      loadIr(irWord(0, 0, {4'd9, 15'h0}));
      nextCycle();
      grc  <= 1;
      rOut <= 1;
      expectBus("busValue R9 through rc", vals[9]);
      r0Val = $urandom | 32'h1;
      loadIr(irWord(0, 0, 19'h0));
      putExt(r0Val);
      gra <= 1;
      rIn <= 1;
      nextCycle();
      gra  <= 1;
      rOut <= 1;
      expectBus("busValue R0", r0Val);
      nextCycle();
      gra   <= 1;
      rOut  <= 1;
      baOut <= 1;
      expectBus("busValue R0 with baOut", 32'h0);
   endtask

   task automatic singleCycleOps();
      aluOp        ops [8];
      logic [31:0] a;
      logic [31:0] b;
      int          cycles;
      ops = '{opAdd, opSub, opAnd, opOr, opShl, opShr, opNeg, opNot};
      for (int i = 0; i < 8; i++) begin
         a = $urandom;
         b = $urandom;
         startAlu(ops[i], a, b);
         waitDone(0, cycles);
         check($sformatf("finished latency %s", ops[i].name()), cycles, 1);
         nextCycle();
         zLoOut <= 1;
         expectBus($sformatf("zLo %s", ops[i].name()), refResult(ops[i], a, b));
         nextCycle();
         zHiOut <= 1;
         expectBus($sformatf("zHi %s", ops[i].name()), 32'h0);
         nextCycle();
         yOut <= 1;
         expectBus($sformatf("yOut %s", ops[i].name()), a);
      end
   endtask

   task automatic mfhiSequence();
      logic [31:0] a;
      logic [31:0] b;
      logic [63:0] prod;
      int          cycles;
      repeat (2) begin
         a    = $urandom;
         b    = $urandom;
         prod = {32'h0, a} * {32'h0, b};
         loadIr(irWord(5, 0, 19'h0));
         startAlu(opMul, a, b);
         waitDone(0, cycles);
         check("finished latency opMul", cycles, mulDivLatency);
         nextCycle();
         zHiOut <= 1;
         hiIn   <= 1;
         nextCycle();
         hiOut <= 1;
         gra   <= 1;
         rIn   <= 1;
         nextCycle();
         gra  <= 1;
         rOut <= 1;
         expectBus("rOut after mfhi", prod[63:32]);
         nextCycle();
         zLoOut <= 1;
         loIn   <= 1;
         nextCycle();
         loOut <= 1;
         expectBus("loOut", prod[31:0]);
      end
   endtask

   task automatic runDiv(input logic [31:0] a, input logic [31:0] b);
      logic [31:0] quot;
      logic [31:0] rem;
      int          cycles;
      quot = (b == 0) ? 32'hffff_ffff : a / b;
      rem  = (b == 0) ? a : a % b;
      startAlu(opDiv, a, b);
      waitDone(0, cycles);
      check("finished latency opDiv", cycles, mulDivLatency);
      nextCycle();
      zLoOut <= 1;
      expectBus("zLo quotient", quot);
      nextCycle();
      zHiOut <= 1;
      expectBus("zHi remainder", rem);
   endtask

   task automatic memAndPc();
      logic [31:0] addrs [3];
      logic [31:0] vals [3];
      logic [31:0] pcStart;
      int          cycles;
      addrs = '{32'd3, 32'd17, 32'd63};
      for (int k = 0; k < 3; k++) begin
         vals[k] = $urandom;
         putExt(addrs[k]);
         marIn <= 1;
         putExt(vals[k]);
         mdrIn <= 1;
         nextCycle();
         write <= 1;
         waitDone(1, cycles);
         check("memFinished latency write", cycles, 1);
      end
      for (int k = 0; k < 3; k++) begin
         putExt(addrs[k]);
         marIn <= 1;
         putExt(32'h0);
         mdrIn <= 1;
         nextCycle();
         mdrOut <= 1;
         expectBus("mdrOut cleared", 32'h0);
         nextCycle();
         read  <= 1;
         mdrIn <= 1;
         waitDone(1, cycles);
         check("memFinished latency read", cycles, 1);
         nextCycle();
         mdrOut <= 1;
         expectBus($sformatf("mdrOut addr %0d", addrs[k]), vals[k]);
      end
      pcStart = $urandom;
      putExt(pcStart);
      pcIn <= 1;
      nextCycle();
      pcOut <= 1;
      expectBus("pcOut", pcStart);
      nextCycle();
      incPc <= 1;
      nextCycle();
      pcOut <= 1;
      expectBus("pcOut after incPc", pcStart + 32'd1);
      // pcIn wins over incPc
      putExt(32'h40);
      pcIn  <= 1;
      incPc <= 1;
      nextCycle();
      pcOut <= 1;
      expectBus("pcOut with pcIn and incPc", 32'h40);
      loadIr(irWord(7, 9, 19'h1_2345));
      nextCycle();
      immOut <= 1;
      expectBus("immOut positive", signExt(19'h1_2345));
      loadIr(irWord(2, 11, 19'h4_0f0f));
      nextCycle();
      immOut <= 1;
      expectBus("immOut negative", signExt(19'h4_0f0f));
   endtask

   initial begin
      void'($urandom(32'h097c_4f53));
      clearStrobes();
      extData <= '0;
      op      <= opAdd;
      rstN    <= 1'b0;
      repeat (4) @(posedge Clock);
      rstN <= 1'b1;
      regReadback();
      mfhiSequence();
      runDiv($urandom, $urandom >> 20);
      runDiv($urandom, $urandom);
      runDiv($urandom, 32'h0);
      // Z high still holds a remainder here, so single-cycle ops must clear it
      singleCycleOps();
      memAndPc();
      $display("RESULT: PASS");
      $finish;
   end

endmodule
